//--- source/cart_config.svh
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// memory timing, in CLK2 cycles
`define CART_ROM_CYCLE_LEN 7
`define CART_RAM_CYCLE_LEN 5

// console clock low this long means the console is off (about 1 ms)
`define CART_DEAD_TIMEOUT 85714

// address bits 23..19 of the save RAM window
`define CART_RAM_REGION 5'b11100

`define CART_ADDR_W 24

`endif

//--- source/cart_pkg.sv
`include "cart_config.svh"

package cart_pkg;

  // ------------------------------------------------------------------
  // request payloads
  // ------------------------------------------------------------------
  typedef logic [`CART_ADDR_W-1:0] addr_t;

  // ROM side is read only, one 16-bit word per access
  typedef struct packed {
    addr_t addr;
    logic  rd;
  } rom_req_t;

  typedef struct packed {
    addr_t      addr;
    logic       we;     // 1 = write
    logic [7:0] wdata;
  } ram_req_t;

  // ------------------------------------------------------------------
  // channel FSM
  // ------------------------------------------------------------------
  typedef enum logic [2:0] {
    st_idle,
    st_cop_addr,   // coprocessor address phase
    st_mcu_addr,
    st_cop_end,
    st_mcu_end
  } chan_state_t;

endpackage

//--- source/mem_if.sv
`timescale 1ns/1ps

interface mem_if #(
  parameter type req_t  = logic,
  parameter int  data_w = 8
) ();

  logic              rq;        // one-cycle request pulse
  req_t              req;       // payload from the requester
  logic              pending;
  req_t              req_held;  // payload latched by the slot
  logic              grant;     // address phase for this requester
  logic              done;      // end cycle
  logic [data_w-1:0] rdata;

  modport requester (
    output rq, req,
    input  pending, grant, done, rdata
  );

  modport slot (
    input  rq, req, grant, done,
    output pending, req_held
  );

  modport channel (
    input  pending, req_held,
    output grant, done, rdata
  );

endinterface

//--- source/snes_bus_sync.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module snes_bus_sync
  import cart_pkg::*;
(
  input  logic  CLK2,
  input  logic  reset,
  input  addr_t snes_addr_in,
  input  logic  snes_read_in,
  input  logic  snes_write_in,
  input  logic  snes_romsel_in,
  input  logic  snes_cpu_clk_in,
  output addr_t snes_addr,
  output logic  pulse_end,
  output logic  cycle_start,
  output logic  cycle_end,
  output logic  snes_hit,
  output logic  snes_saveram,
  output logic  dead,
  output logic  revive
);

  localparam int cnt_w = $clog2(`CART_DEAD_TIMEOUT + 2);

  logic [6:0]       pulse_sr;
  logic [6:0]       cpu_clk_sr;
  logic [6:0]       romsel_sr;
  addr_t            addr_sr [0:5];
  logic             pulse_in;
  logic             romsel;
  logic [cnt_w-1:0] dead_cnt;

  // ------------------------------------------------------------------
  // input filtering
  // ------------------------------------------------------------------
  assign pulse_in = snes_read_in & snes_write_in & ~snes_cpu_clk_in;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      pulse_sr   <= '1;
      cpu_clk_sr <= '0;
      romsel_sr  <= '1;
    end else begin
      pulse_sr   <= {pulse_sr[5:0], pulse_in};
      cpu_clk_sr <= {cpu_clk_sr[5:0], snes_cpu_clk_in};
      romsel_sr  <= {romsel_sr[5:0], snes_romsel_in};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_sr[0] <= snes_addr_in;
    for (int i = 1; i < 6; i++) addr_sr[i] <= addr_sr[i-1];
  end

  assign snes_addr    = addr_sr[5] & addr_sr[4];  // glitch filter on late taps
  assign romsel       = romsel_sr[5] & romsel_sr[4];
  assign snes_saveram = snes_addr[`CART_ADDR_W-1 -: 5] == `CART_RAM_REGION;
  assign snes_hit     = ~romsel | snes_saveram;

  // edges, bit 6 is the oldest sample
  assign pulse_end   = pulse_sr[6:1] == 6'b000011;
  assign cycle_start = cpu_clk_sr[6:1] == 6'b000001;
  assign cycle_end   = cpu_clk_sr[6:1] == 6'b111110;

  // ------------------------------------------------------------------
  // dead console watchdog
  // ------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (reset || cpu_clk_sr[1]) begin
      dead_cnt <= '0;
    end else if (!dead) begin
      dead_cnt <= dead_cnt + 1'b1;  // stops once dead
    end
  end

  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead   <= 1'b0;
      revive <= 1'b0;
    end else begin
      revive <= dead & cpu_clk_sr[1];  // clock is back
      if (cpu_clk_sr[1]) dead <= 1'b0;
      else if (dead_cnt > cnt_w'(`CART_DEAD_TIMEOUT)) dead <= 1'b1;
    end
  end

endmodule

//--- source/mem_request_slot.sv
`timescale 1ns/1ps

module mem_request_slot
  import cart_pkg::*;
#(
  parameter type req_t = rom_req_t
) (
  input  logic CLK2,
  input  logic reset,
  input  logic revive,
  mem_if.slot  bus,
  output logic rdy
);

  req_t held_q;
  logic finish;

  // an end cycle cut by revive is an abort, the channel retries it
  assign finish = bus.done & ~revive;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      bus.pending <= 1'b0;
      rdy         <= 1'b1;
    end else if (bus.rq) begin
      bus.pending <= 1'b1;
      rdy         <= 1'b0;
    end else if (finish) begin
      bus.pending <= 1'b0;
      rdy         <= 1'b1;
    end
  end

  // payload stays frozen while the channel drives it onto the memory
  always_ff @(posedge CLK2) begin
    if (bus.rq && !bus.grant) begin
      held_q <= bus.req;
    end
  end

  assign bus.req_held = held_q;

endmodule

//--- source/mem_channel.sv
`timescale 1ns/1ps

module mem_channel
  import cart_pkg::*;
#(
  parameter int  cycle_len = 7,
  parameter type req_t     = rom_req_t,
  parameter int  data_w    = 16
) (
  input  logic              CLK2,
  input  logic              reset,
  input  logic              slot_event,   // free slot edge from the console
  input  logic              cycle_start,
  input  logic              snes_busy,    // console owns this memory now
  input  logic              dead,
  input  logic              revive,
  mem_if.channel            copro,
  mem_if.channel            mcu,
  input  addr_t             mem_addr_snes,
  output addr_t             mem_addr,
  output logic [data_w-1:0] mem_wdata,
  output logic              mem_we,
  input  logic [data_w-1:0] mem_rdata
);

  localparam int dly_w  = $clog2(cycle_len + 1);
  localparam int tail_w = $bits(req_t) - $bits(addr_t);

  chan_state_t       state;
  logic [dly_w-1:0]  delay;
  logic              free_strobe;
  logic              free_slot;
  logic              in_addr;
  logic              wr_req;
  logic [data_w-1:0] rdata_q;
  req_t              act;

  // ------------------------------------------------------------------
  // slot detection
  // ------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (reset) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~snes_busy;  // whole console cycle is ours
    end
  end

  assign free_slot = slot_event | free_strobe;

  // ------------------------------------------------------------------
  // access FSM
  // ------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (reset || revive) begin
      state <= st_idle;  // revive drops an access in flight
    end else begin
      case (state)
        st_idle: begin
          if (free_slot || dead) begin
            if (copro.pending) state <= st_cop_addr;
            else if (mcu.pending) state <= st_mcu_addr;
          end
        end
        st_cop_addr: if (delay == '0) state <= st_cop_end;
        st_mcu_addr: if (delay == '0) state <= st_mcu_end;
        default:     state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge CLK2) begin
    if (state == st_idle) delay <= dly_w'(cycle_len);
    else if (in_addr) delay <= delay - 1'b1;
  end

  // last sample of the address phase is kept
  always_ff @(posedge CLK2) begin
    if (in_addr) rdata_q <= mem_rdata;
  end

  assign in_addr = (state == st_cop_addr) || (state == st_mcu_addr);
  assign act     = (state == st_cop_addr || state == st_cop_end) ? copro.req_held
                                                                 : mcu.req_held;

  if (tail_w > 1) begin : g_write
    assign wr_req    = act.we;
    assign mem_wdata = act.wdata;
  end else begin : g_read_only  // address plus a read flag
    assign wr_req    = 1'b0;
    assign mem_wdata = '0;
  end

  assign mem_addr = (state == st_idle) ? mem_addr_snes : act.addr;
  assign mem_we   = ~(in_addr & wr_req);

  assign copro.grant = state == st_cop_addr;
  assign mcu.grant   = state == st_mcu_addr;
  assign copro.done  = state == st_cop_end;
  assign mcu.done    = state == st_mcu_end;
  assign copro.rdata = rdata_q;
  assign mcu.rdata   = rdata_q;

endmodule

//--- source/mcu_port_router.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module mcu_port_router
  import cart_pkg::*;
(
  input  logic       CLK2,
  input  logic       reset,
  input  logic       mcu_rrq,
  input  logic       mcu_wrq,
  input  addr_t      mcu_addr,
  input  logic [7:0] mcu_wdata,
  mem_if.requester   rom,
  mem_if.requester   ram,
  input  logic       rom_rdy,
  input  logic       ram_rdy,
  output logic       mcu_rdy,
  output logic [7:0] mcu_rdata
);

  logic is_ram;
  logic odd_q;

  assign is_ram = mcu_addr[`CART_ADDR_W-1 -: 5] == `CART_RAM_REGION;

  // ROM side only takes reads
  assign rom.rq  = mcu_rrq & ~is_ram;
  assign rom.req = '{addr: mcu_addr, rd: 1'b1};
  assign ram.rq  = (mcu_rrq | mcu_wrq) & is_ram;
  assign ram.req = '{addr: mcu_addr, we: mcu_wrq, wdata: mcu_wdata};

  assign mcu_rdy = rom_rdy & ram_rdy;

  always_ff @(posedge CLK2) begin
    if (rom.rq) odd_q <= mcu_addr[0];  // byte lane of the ROM word
  end

  always_ff @(posedge CLK2) begin
    if (reset) begin
      mcu_rdata <= '0;
    end else if (rom.done) begin
      mcu_rdata <= odd_q ? rom.rdata[15:8] : rom.rdata[7:0];
    end else if (ram.done) begin
      mcu_rdata <= ram.rdata;
    end
  end

endmodule

//--- source/cart_mem_top.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module cart_mem_top
  import cart_pkg::*;
(
  input  logic CLK2,
  input  logic reset,
  input  addr_t snes_addr_in,
  input  logic snes_read_in, snes_write_in, snes_romsel_in, snes_cpu_clk_in,
  input  logic mcu_rrq, mcu_wrq,
  input  addr_t mcu_addr,
  input  logic [7:0] mcu_wdata,
  output logic mcu_rdy,
  output logic [7:0] mcu_rdata,
  input  logic cop_rom_rrq,
  input  addr_t cop_rom_addr,
  output logic cop_rom_rdy,
  output logic [15:0] cop_rom_rdata,
  input  logic cop_ram_rrq, cop_ram_wrq,
  input  addr_t cop_ram_addr,
  input  logic [7:0] cop_ram_wdata,
  output logic cop_ram_rdy,
  output logic [7:0] cop_ram_rdata,
  output addr_t rom_addr,
  input  logic [15:0] rom_rdata,
  output logic rom_we,
  output addr_t ram_addr,
  output logic [7:0] ram_wdata,
  input  logic [7:0] ram_rdata,
  output logic ram_we
);

  addr_t snes_addr;
  logic  pulse_end, cycle_start, cycle_end, snes_hit, snes_saveram, dead, revive;
  logic  mcu_rom_rdy, mcu_ram_rdy;

  mem_if #(.req_t(rom_req_t), .data_w(16)) cop_rom_if (), mcu_rom_if ();
  mem_if #(.req_t(ram_req_t), .data_w(8))  cop_ram_if (), mcu_ram_if ();

  // coprocessor pins straight into requests
  assign cop_rom_if.rq  = cop_rom_rrq;
  assign cop_rom_if.req = '{addr: cop_rom_addr, rd: 1'b1};
  assign cop_ram_if.rq  = cop_ram_rrq | cop_ram_wrq;
  assign cop_ram_if.req = '{addr: cop_ram_addr, we: cop_ram_wrq, wdata: cop_ram_wdata};
  assign cop_rom_rdata  = cop_rom_if.rdata;
  assign cop_ram_rdata  = cop_ram_if.rdata;

  snes_bus_sync sync_i (.*);

  mcu_port_router router_i (.CLK2, .reset, .mcu_rrq, .mcu_wrq, .mcu_addr, .mcu_wdata,
    .rom(mcu_rom_if.requester), .ram(mcu_ram_if.requester), .rom_rdy(mcu_rom_rdy),
    .ram_rdy(mcu_ram_rdy), .mcu_rdy, .mcu_rdata);

  mem_request_slot #(.req_t(rom_req_t)) cop_rom_slot (.CLK2, .reset, .revive,
    .bus(cop_rom_if.slot), .rdy(cop_rom_rdy));
  mem_request_slot #(.req_t(rom_req_t)) mcu_rom_slot (.CLK2, .reset, .revive,
    .bus(mcu_rom_if.slot), .rdy(mcu_rom_rdy));
  mem_request_slot #(.req_t(ram_req_t)) cop_ram_slot (.CLK2, .reset, .revive,
    .bus(cop_ram_if.slot), .rdy(cop_ram_rdy));
  mem_request_slot #(.req_t(ram_req_t)) mcu_ram_slot (.CLK2, .reset, .revive,
    .bus(mcu_ram_if.slot), .rdy(mcu_ram_rdy));

  mem_channel #(.cycle_len(`CART_ROM_CYCLE_LEN), .req_t(rom_req_t), .data_w(16)) rom_chan (
    .CLK2, .reset, .slot_event(pulse_end), .cycle_start,
    .snes_busy(snes_hit & ~snes_saveram), .dead, .revive,
    .copro(cop_rom_if.channel), .mcu(mcu_rom_if.channel), .mem_addr_snes(snes_addr),
    .mem_addr(rom_addr), .mem_wdata(), .mem_we(rom_we), .mem_rdata(rom_rdata));

  mem_channel #(.cycle_len(`CART_RAM_CYCLE_LEN), .req_t(ram_req_t), .data_w(8)) ram_chan (
    .CLK2, .reset, .slot_event(cycle_end), .cycle_start,
    .snes_busy(snes_hit & snes_saveram), .dead, .revive,
    .copro(cop_ram_if.channel), .mcu(mcu_ram_if.channel), .mem_addr_snes(snes_addr),
    .mem_addr(ram_addr), .mem_wdata(ram_wdata), .mem_we(ram_we), .mem_rdata(ram_rdata));

endmodule

//--- testbench/cart_mem_properties.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module cart_mem_properties
  import cart_pkg::*;
(
  input logic        CLK2,
  input logic        reset,
  input logic        mcu_rrq, mcu_wrq,
  input addr_t       mcu_addr,
  input logic [7:0]  mcu_wdata,
  input logic        mcu_rdy,
  input logic [7:0]  mcu_rdata,
  input logic        cop_rom_rrq, cop_rom_rdy, cop_ram_rrq, cop_ram_rdy,
  input addr_t       cop_rom_addr, cop_ram_addr,
  input logic [15:0] cop_rom_rdata,
  input logic [7:0]  cop_ram_rdata,
  input addr_t       rom_addr, ram_addr,
  input logic [15:0] rom_rdata,
  input logic [7:0]  ram_wdata, ram_rdata,
  input logic        rom_we, ram_we,
  input logic        pulse_end, dead,
  input chan_state_t rom_state, ram_state,
  input logic        rom_cop_pend, rom_mcu_pend
);

  int          fail_cnt = 0;
  addr_t       rd_addr_q;
  logic        rom_last;   // last MCU access went to ROM
  logic        mcu_open;   // MCU request issued, ready not back yet
  logic [7:0]  exp_q;      // expected byte from the ROM model
  addr_t       wr_addr_q;
  logic [7:0]  wr_data_q;
  addr_t       cop_addr_q;
  logic [15:0] cop_word_q;
  addr_t       cop_ram_addr_q;
  logic [7:0]  cop_byte_q;

  // ------------------------------------------------------------------
  // reference values from the request pins and the memory model
  // ------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (mcu_rrq) rd_addr_q <= mcu_addr;
    if (cop_rom_rrq) cop_addr_q <= cop_rom_addr;
    if (cop_ram_rrq) cop_ram_addr_q <= cop_ram_addr;
    if (mcu_wrq) begin
      wr_addr_q <= mcu_addr;
      wr_data_q <= mcu_wdata;
    end
    // model output while the bus carries the requested address
    if (rom_addr == rd_addr_q) exp_q <= rd_addr_q[0] ? rom_rdata[15:8] : rom_rdata[7:0];
    if (rom_addr == cop_addr_q) cop_word_q <= rom_rdata;
    if (ram_addr == cop_ram_addr_q) cop_byte_q <= ram_rdata;
    if (reset) rom_last <= 1'b0;
    else if (rom_state == st_mcu_end) rom_last <= 1'b1;
    else if (ram_state == st_mcu_end) rom_last <= 1'b0;
    if (reset) mcu_open <= 1'b0;
    else if (mcu_rrq || mcu_wrq) mcu_open <= 1'b1;
    else if (mcu_rdy) mcu_open <= 1'b0;
  end

  default disable iff (reset);

  a_reset: assert property (@(posedge CLK2)
    $fell(reset) |-> mcu_rdy && cop_rom_rdy && cop_ram_rdy && rom_we && ram_we)
    else begin
      fail_cnt++;
      $error("ready or write enable not idle after reset");
    end

  a_rdata: assert property (@(posedge CLK2) $rose(mcu_rdy) && rom_last |=> mcu_rdata == exp_q)
    else begin
      fail_cnt++;
      $error("** Error %0t mcu_rdata %h expected %h", $time, $sampled(mcu_rdata), exp_q);
    end

  a_cop_rom_data: assert property (@(posedge CLK2)
    $rose(cop_rom_rdy) |=> cop_rom_rdata == cop_word_q)
    else begin
      fail_cnt++;
      $error("** Error %0t cop_rom_rdata %h expected %h", $time,
             $sampled(cop_rom_rdata), cop_word_q);
    end

  a_cop_ram_data: assert property (@(posedge CLK2)
    $rose(cop_ram_rdy) |=> cop_ram_rdata == cop_byte_q)
    else begin
      fail_cnt++;
      $error("** Error %0t cop_ram_rdata %h expected %h", $time,
             $sampled(cop_ram_rdata), cop_byte_q);
    end

  a_we_len: assert property (@(posedge CLK2)
    $fell(ram_we) |-> (!ram_we) [*`CART_RAM_CYCLE_LEN+1] ##1 ram_we)
    else begin
      fail_cnt++;
      $error("ram_we low for the wrong number of cycles");
    end

  a_wr_match: assert property (@(posedge CLK2)
    ram_state == st_mcu_addr && !ram_we |-> ram_addr == wr_addr_q && ram_wdata == wr_data_q)
    else begin
      fail_cnt++;
      $error("** Error %0t ram_addr/ram_wdata %h/%h expected %h/%h", $time,
             $sampled(ram_addr), $sampled(ram_wdata), wr_addr_q, wr_data_q);
    end

  // coprocessor wins when both wait in idle
  a_cop_first: assert property (@(posedge CLK2)
    (rom_state == st_idle && rom_cop_pend && rom_mcu_pend) ##1 (rom_state != st_idle)
      |-> rom_addr == cop_addr_q)
    else begin
      fail_cnt++;
      $error("** Error %0t rom_addr %h expected %h", $time, $sampled(rom_addr), cop_addr_q);
    end

  a_rom_slot: assert property (@(posedge CLK2)
    (rom_state == st_idle) ##1 (rom_state != st_idle) |-> $past(pulse_end || dead))
    else begin
      fail_cnt++;
      $error("ROM access started outside a free slot");
    end

  a_rom_lat: assert property (@(posedge CLK2)
    $rose(rom_state == st_mcu_addr) |-> ##(`CART_ROM_CYCLE_LEN+2) $rose(mcu_rdy))
    else begin
      fail_cnt++;
      $error("ROM access latency wrong");
    end

  a_ram_lat: assert property (@(posedge CLK2)
    $rose(ram_state == st_mcu_addr) |-> ##(`CART_RAM_CYCLE_LEN+2) $rose(mcu_rdy))
    else begin
      fail_cnt++;
      $error("RAM access latency wrong");
    end

  a_rdy_pend: assert property (@(posedge CLK2) $rose(mcu_rdy) |-> mcu_open)
    else begin
      fail_cnt++;
      $error("mcu_rdy rose with no request pending");
    end

endmodule

bind cart_mem_top cart_mem_properties props_i (.*,
  .rom_state(rom_chan.state), .ram_state(ram_chan.state),
  .rom_cop_pend(cop_rom_if.pending), .rom_mcu_pend(mcu_rom_if.pending));

//--- testbench/cart_mem_tb.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module cart_mem_tb
  import cart_pkg::*;
();

  logic        CLK2, reset;
  addr_t       snes_addr_in;
  logic        snes_read_in, snes_write_in, snes_romsel_in, snes_cpu_clk_in;
  logic        mcu_rrq, mcu_wrq, mcu_rdy;
  addr_t       mcu_addr;
  logic [7:0]  mcu_wdata, mcu_rdata;
  logic        cop_rom_rrq, cop_rom_rdy;
  addr_t       cop_rom_addr;
  logic [15:0] cop_rom_rdata;
  logic        cop_ram_rrq, cop_ram_wrq, cop_ram_rdy;
  addr_t       cop_ram_addr;
  logic [7:0]  cop_ram_wdata, cop_ram_rdata;
  addr_t       rom_addr, ram_addr;
  logic [15:0] rom_rdata;
  logic [7:0]  ram_wdata, ram_rdata;
  logic        rom_we, ram_we;
  logic [15:0] rom_mem [0:1023];
  logic [7:0]  ram_mem [0:1023];
  logic        console_on = 1'b0;
  logic [3:0]  con_div = '0;
  int          timeouts = 0;

  cart_mem_top dut_i (.*);

  initial begin
    CLK2 = 1'b0;
    forever #50 CLK2 = ~CLK2;
  end

  // ------------------------------------------------------------------
  // memory models and console clock
  // ------------------------------------------------------------------
  assign rom_rdata = rom_mem[rom_addr[10:1]];  // one word per byte pair
  assign ram_rdata = ram_mem[ram_addr[9:0]];

  always @(posedge CLK2) begin
    if (!ram_we) ram_mem[ram_addr[9:0]] <= ram_wdata;
  end

  always @(posedge CLK2) begin
    if (console_on) begin
      con_div <= (con_div == 4'd11) ? 4'd0 : con_div + 4'd1;
      snes_cpu_clk_in <= #1 (con_div < 4'd6);  // 12 CLK2 per console cycle
    end else begin
      snes_cpu_clk_in <= #1 1'b0;  // stopped console holds its clock low
    end
  end

  function automatic addr_t pick_rom_addr();
    return {4'h0, 20'($urandom)};
  endfunction

  function automatic addr_t pick_ram_addr();
    return {`CART_RAM_REGION, 19'($urandom)};
  endfunction

  task automatic wait_idle(input string what);
    int n;
    n = 0;
    while (!(mcu_rdy && cop_rom_rdy && cop_ram_rdy) && n < 200) begin
      @(negedge CLK2);
      n++;
    end
    if (n >= 200) begin
      timeouts++;
      $display("timeout at %0t: %s never completed", $time, what);
    end
  endtask

  task automatic wait_dead();
    int n;
    n = 0;
    while (!dut_i.dead && n < `CART_DEAD_TIMEOUT + 100) begin
      @(negedge CLK2);
      n++;
    end
    if (!dut_i.dead) begin
      timeouts++;
      $display("timeout at %0t: console never flagged dead", $time);
    end
  endtask

  task automatic mcu_req(input addr_t a, input logic wr, input logic [7:0] d);
    @(posedge CLK2);
    #1;
    mcu_addr  = a;
    mcu_wdata = d;
    mcu_rrq   = ~wr;
    mcu_wrq   = wr;
    @(posedge CLK2);
    #1;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    wait_idle("MCU request");
  endtask

  task automatic dual_rom_read(input addr_t cop_a, input addr_t mcu_a);
    @(posedge CLK2);
    #1;
    cop_rom_addr = cop_a;
    cop_rom_rrq  = 1'b1;
    mcu_addr     = mcu_a;
    mcu_rrq      = 1'b1;
    @(posedge CLK2);
    #1;
    cop_rom_rrq = 1'b0;
    mcu_rrq     = 1'b0;
    wait_idle("coprocessor and MCU ROM reads");
  endtask

  task automatic cop_ram_read(input addr_t a);
    @(posedge CLK2);
    #1;
    cop_ram_addr = a;
    cop_ram_rrq  = 1'b1;
    @(posedge CLK2);
    #1;
    cop_ram_rrq = 1'b0;
    wait_idle("coprocessor RAM read");
  endtask

  // ------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------
  initial begin
    void'($urandom(14752));
    foreach (rom_mem[i]) rom_mem[i] = 16'($urandom);
    foreach (ram_mem[i]) ram_mem[i] = 8'($urandom);
    reset           = 1'b1;
    snes_addr_in    = '0;
    snes_read_in    = 1'b1;
    snes_write_in   = 1'b1;
    snes_romsel_in  = 1'b0;   // console sits on ROM
    snes_cpu_clk_in = 1'b0;
    mcu_rrq         = 1'b0;
    mcu_wrq         = 1'b0;
    mcu_addr        = '0;
    mcu_wdata       = '0;
    cop_rom_rrq     = 1'b0;
    cop_rom_addr    = '0;
    cop_ram_rrq     = 1'b0;
    cop_ram_wrq     = 1'b0;
    cop_ram_addr    = '0;
    cop_ram_wdata   = '0;
    repeat (3) @(posedge CLK2);
    #1;
    reset = 1'b0;

    // live console, ROM only in pulse_end slots
    console_on = 1'b1;
    repeat (20) @(posedge CLK2);
    for (int i = 0; i < 3; i++) begin
      mcu_req(pick_rom_addr(), 1'b0, 8'h00);
      mcu_req(pick_ram_addr(), 1'b1, 8'($urandom));
      dual_rom_read(pick_rom_addr(), pick_rom_addr());
      cop_ram_read(pick_ram_addr());
    end

    // stop the console clock low until the watchdog fires
    @(posedge CLK2);
    #1;
    console_on = 1'b0;
    wait_dead();
    for (int i = 0; i < 4; i++) begin
      mcu_req(pick_rom_addr(), 1'b0, 8'h00);
      mcu_req(pick_ram_addr(), 1'b1, 8'($urandom));
      dual_rom_read(pick_rom_addr(), pick_rom_addr());
      cop_ram_read(pick_ram_addr());
    end

    repeat (4) @(posedge CLK2);
    $display("assertion failures %0d, timeouts %0d", dut_i.props_i.fail_cnt, timeouts);
    if (dut_i.props_i.fail_cnt == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+source
source/cart_pkg.sv
source/mem_if.sv
source/snes_bus_sync.sv
source/mem_request_slot.sv
source/mem_channel.sv
source/mcu_port_router.sv
source/cart_mem_top.sv
testbench/cart_mem_properties.sv
testbench/cart_mem_tb.sv
